// File: flist.f
src/mania_pkg.sv
src/boot_sequencer.sv
src/tick_timer.sv
src/beatmap_loader.sv
src/beatmap_ram.sv
src/section_table.sv
src/audio_player.sv
src/mania_core.sv
sim/mania_core_assert.sv
sim/tb_mania_core.sv

// File: sim/tb_mania_core.sv
// rhythm core testbench
`timescale 1ns/1ns

module tb_mania_core import mania_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int NUM_SAMPLES = 8;

	logic              CLK;
	logic              RESET_L;
	logic [7:0]        song_selection;
	storage_req_t      storage_req;
	storage_rsp_t      storage_rsp;
	logic              song_restart;
	logic              song_request;
	logic [BYTE_W-1:0] song_data;
	logic              song_data_ready;
	logic [BYTE_W-1:0] audio_out;
	logic              audio_en;
	logic              update_tick;
	section_table_t    sections;
	core_state_e       core_state;

	int unsigned seed = 1;
	logic [7:0] image [0:255];
	int image_len = 0;
	int sizes [NUM_SECTIONS];
	int cycle = 0;
	int run_start = -1;
	int checks = 0;
	int mismatches = 0;
	int other_errors = 0;
	int restart_cnt = 0;
	int song_restart_cnt = 0;
	int upd_cnt = 0;
	int req_cnt = 0;
	int samples_done = 0;

	mania_core i_mania_core (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) cycle++;

	function int unsigned next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return (seed >> 16) & 32'h7fff;
	endfunction

	task compare(input string name, input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task push_word(input logic [WORD_W-1:0] w);
		for (int b = 0; b < WORD_BYTES; b++) begin
			image[image_len] = w[BYTE_W*b +: BYTE_W]; // low byte first
			image_len++;
		end
	endtask

	// size word, then the section's filler words
	task build_image();
		logic [WORD_W-1:0] w;
		for (int k = 0; k < NUM_SECTIONS; k++) begin
			sizes[k] = 1 + next_random() % 20;
			push_word(WORD_W'(sizes[k]));
			for (int j = 0; j < sizes[k]; j++) begin
				w = (next_random() << 12) ^ next_random();
				push_word(w);
			end
		end
		for (int b = 0; b < 2; b++) begin
			image[image_len] = next_random(); // partial word, never written
			image_len++;
		end
	endtask

	function automatic section_table_t expected_sections(input int sz [NUM_SECTIONS]);
		section_table_t t;
		logic [ADDR_W-1:0] base;
		base = 1;
		for (int k = 0; k < NUM_SECTIONS; k++) begin
			t[k].size = sz[k];
			t[k].base = base;
			base = base + sz[k] + 1;
		end
		return t;
	endfunction

	task check_idle(input string when);
		compare({when, " core_state"}, ST_INIT, core_state);
		compare({when, " audio_en"}, 0, audio_en);
		compare({when, " update_tick"}, 0, update_tick);
		compare({when, " song_request"}, 0, song_request);
		compare({when, " audio_out"}, 0, audio_out);
	endtask

	// storage source with random latency
	initial begin : storage_model
		int wait_cnt;
		int byte_idx;
		bit busy;
		busy = 0;
		byte_idx = 0;
		forever begin
			@(posedge CLK);
			#1;
			storage_rsp.data_ready = 1'b0;
			storage_rsp.transmit_finished = 1'b0;
			if (busy) begin
				wait_cnt--;
				if (wait_cnt == 0) begin
					busy = 0;
					if (byte_idx < image_len) begin
						storage_rsp.data = image[byte_idx];
						storage_rsp.data_ready = 1'b1;
						byte_idx++;
					end else begin
						storage_rsp.transmit_finished = 1'b1;
					end
				end
			end
			if (storage_req.restart) begin
				restart_cnt++;
				byte_idx = 0;
				compare("storage init_index", song_selection, storage_req.init_index);
				compare("storage init_aux_info", 0, storage_req.init_aux_info);
			end
			if (storage_req.request_data) begin
				if (busy) begin
					other_errors++;
					$display("error: new storage request while one is still outstanding");
				end
				busy = 1;
				wait_cnt = 1 + next_random() % 4;
			end
		end
	end

	// song source, checks the latch one cycle after each sample
	initial begin : song_model
		int wait_cnt;
		bit busy;
		logic [BYTE_W-1:0] sent;
		busy = 0;
		sent = '0;
		forever begin
			@(posedge CLK);
			#1;
			if (song_data_ready) begin
				song_data_ready = 1'b0;
				compare("audio_out after sample", sent, audio_out);
				samples_done++;
			end
			if (busy) begin
				wait_cnt--;
				if (wait_cnt == 0) begin
					busy = 0;
					sent = next_random();
					song_data = sent;
					song_data_ready = 1'b1;
				end
			end
			if (song_request) begin
				if (busy) begin
					other_errors++;
					$display("error: song request while a sample is still pending");
				end
				busy = 1;
				wait_cnt = 1 + next_random() % 4;
			end
		end
	end

	// tick and pulse timing, sampled mid-cycle
	always @(negedge CLK) begin
		if (RESET_L === 1'b1) begin
			if (core_state == ST_RUN && run_start < 0) begin
				run_start = cycle;
			end
			compare("audio_en while running", run_start >= 0, audio_en);
			if (song_restart) begin
				song_restart_cnt++;
				if (run_start >= 0) begin
					other_errors++;
					$display("error: song restart pulsed after the core started running");
				end
			end
			if (update_tick) begin
				if (run_start < 0) begin
					other_errors++;
					$display("error: update tick before the core started running");
				end else begin
					compare("update tick offset", UPDATE_PERIOD - 1 + upd_cnt * UPDATE_PERIOD,
						cycle - run_start);
				end
				upd_cnt++;
			end
			if (song_request) begin
				if (run_start < 0) begin
					other_errors++;
					$display("error: song request before the core started running");
				end else begin
					compare("song request offset",
						(PLAY_DELAY + 1 + req_cnt) * AUDIO_PERIOD, cycle - run_start);
				end
				req_cnt++;
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (image_len > 0);
		limit = RESET_CYCLES + image_len * 6 + 20 * AUDIO_PERIOD;
		repeat (limit) @(posedge CLK);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		section_table_t exp_tab;
		int assert_fails;
		RESET_L = 1'b0;
		song_selection = 8'h2a;
		storage_rsp = '0;
		song_data = '0;
		song_data_ready = 1'b0;
		build_image();

		repeat (RESET_CYCLES - 1) @(posedge CLK);
		#1;
		check_idle("in reset");
		@(posedge CLK);
		#1;
		RESET_L = 1'b1;
		check_idle("after reset");

		wait (run_start >= 0);
		exp_tab = expected_sections(sizes);
		for (int k = 0; k < NUM_SECTIONS; k++) begin
			compare($sformatf("section %0d size", k), exp_tab[k].size, sections[k].size);
			compare($sformatf("section %0d base", k), exp_tab[k].base, sections[k].base);
		end

		wait (samples_done >= NUM_SAMPLES && upd_cnt >= 2);
		repeat (2) @(posedge CLK);
		compare("storage restart count", 1, restart_cnt);
		compare("song restart count", 1, song_restart_cnt);

		assert_fails = i_mania_core.i_mania_core_assert.assert_errors;
		$display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
			checks, mismatches, other_errors, assert_fails);
		if (mismatches == 0 && other_errors == 0 && assert_fails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim/mania_core_assert.sv
// rhythm core protocol assertions
`timescale 1ns/1ns

module mania_core_assert import mania_pkg::*; (
	input logic         CLK,
	input logic         RESET_L,
	input storage_req_t storage_req,
	input core_state_e  core_state,
	input logic         update_tick,
	input logic         song_request,
	input logic         audio_en,
	input logic         load_start,
	input logic         load_done,
	input logic         table_start,
	input logic         table_done
);

	int assert_errors = 0;

	property single_pulse(sig);
		@(posedge CLK) disable iff (!RESET_L) sig |=> !sig;
	endproperty

	// storage only talked to while loading
	req_in_load: assert property (@(posedge CLK) disable iff (!RESET_L)
		storage_req.request_data |-> core_state == ST_W_LOAD)
		else begin
			$error("storage request outside the load wait state");
			assert_errors++;
		end

	tick_when_en: assert property (@(posedge CLK) disable iff (!RESET_L)
		update_tick |-> audio_en)
		else begin
			$error("update tick while not running");
			assert_errors++;
		end

	request_when_en: assert property (@(posedge CLK) disable iff (!RESET_L)
		song_request |-> audio_en)
		else begin
			$error("song request while not running");
			assert_errors++;
		end

	load_start_pulse: assert property (single_pulse(load_start))
		else begin
			$error("load start longer than one cycle");
			assert_errors++;
		end

	load_done_pulse: assert property (single_pulse(load_done))
		else begin
			$error("load done longer than one cycle");
			assert_errors++;
		end

	table_start_pulse: assert property (single_pulse(table_start))
		else begin
			$error("table start longer than one cycle");
			assert_errors++;
		end

	table_done_pulse: assert property (single_pulse(table_done))
		else begin
			$error("table done longer than one cycle");
			assert_errors++;
		end

endmodule

bind mania_core mania_core_assert i_mania_core_assert (.*);

// File: src/mania_core.sv
// rhythm game boot and play core
`timescale 1ns/1ns

module mania_core import mania_pkg::*; (
	input  logic              CLK,
	input  logic              RESET_L,
	input  logic [7:0]        song_selection,
	output storage_req_t      storage_req,
	input  storage_rsp_t      storage_rsp,
	output logic              song_restart,
	output logic              song_request,
	input  logic [BYTE_W-1:0] song_data,
	input  logic              song_data_ready,
	output logic [BYTE_W-1:0] audio_out,
	output logic              audio_en,
	output logic              update_tick,
	output section_table_t    sections,
	output core_state_e       core_state
);

	logic load_start;
	logic load_done;
	logic table_start;
	logic table_done;
	logic running;
	logic audio_tick;

	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [WORD_W-1:0] wr_data;
	logic              rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic [WORD_W-1:0] rd_data;

	boot_sequencer i_boot_sequencer (
		.CLK          (CLK),
		.RESET_L      (RESET_L),
		.load_done    (load_done),
		.table_done   (table_done),
		.load_start   (load_start),
		.table_start  (table_start),
		.song_restart (song_restart),
		.running      (running),
		.state        (core_state)
	);

	tick_timer i_tick_timer (
		.CLK         (CLK),
		.RESET_L     (RESET_L),
		.running     (running),
		.update_tick (update_tick),
		.audio_tick  (audio_tick)
	);

	beatmap_loader i_beatmap_loader (
		.CLK            (CLK),
		.RESET_L        (RESET_L),
		.start          (load_start),
		.song_selection (song_selection),
		.req            (storage_req),
		.rsp            (storage_rsp),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.done           (load_done)
	);

	beatmap_ram i_beatmap_ram (
		.CLK     (CLK),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	section_table i_section_table (
		.CLK      (CLK),
		.RESET_L  (RESET_L),
		.start    (table_start),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.sections (sections),
		.done     (table_done)
	);

	audio_player i_audio_player (
		.CLK             (CLK),
		.RESET_L         (RESET_L),
		.running         (running),
		.audio_tick      (audio_tick),
		.song_data       (song_data),
		.song_data_ready (song_data_ready),
		.song_request    (song_request),
		.audio_out       (audio_out),
		.audio_en        (audio_en)
	);

endmodule

// File: src/audio_player.sv
// song sample pacing and latch
`timescale 1ns/1ns

module audio_player import mania_pkg::*; (
	input  logic              CLK,
	input  logic              RESET_L,
	input  logic              running,
	input  logic              audio_tick,
	input  logic [BYTE_W-1:0] song_data,
	input  logic              song_data_ready,
	output logic              song_request,
	output logic [BYTE_W-1:0] audio_out,
	output logic              audio_en
);

	logic [DELAY_CNT_W-1:0] delay_cnt;
	logic delay_over;
	logic play_tick;

	assign delay_over = (delay_cnt == DELAY_CNT_W'(PLAY_DELAY));
	assign play_tick = running && audio_tick;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			delay_cnt <= '0;
			song_request <= 1'b0;
			audio_out <= '0;
		end else begin
			song_request <= play_tick && delay_over;
			if (play_tick && !delay_over) begin
				delay_cnt <= delay_cnt + 1'b1; // start delay
			end
			if (song_data_ready) begin
				audio_out <= song_data;
			end
		end
	end

	assign audio_en = running;

endmodule

// File: src/section_table.sv
// difficulty section table walker
`timescale 1ns/1ns

module section_table import mania_pkg::*; (
	input  logic              CLK,
	input  logic              RESET_L,
	input  logic              start,
	output logic              rd_en,
	output logic [ADDR_W-1:0] rd_addr,
	input  logic [WORD_W-1:0] rd_data,
	output section_table_t    sections,
	output logic              done
);

	logic active;
	logic [SEC_IDX_W-1:0] idx;
	logic [PHASE_W-1:0] phase;
	section_entry_t prev;
	logic [ADDR_W-1:0] prev_end;
	logic entry_last;
	logic idx_last;

	assign prev = sections[idx - 1'b1];
	assign prev_end = prev.base + prev.size; // size word of the next section
	assign entry_last = active && (phase == PHASE_W'(ENTRY_CYCLES - 1));
	assign idx_last = (idx == SEC_IDX_W'(NUM_SECTIONS - 1));

	assign rd_en = active && (phase == '0);
	assign rd_addr = (idx == '0) ? '0 : prev_end;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			active <= 1'b0;
			idx <= '0;
			phase <= '0;
			done <= 1'b0;
		end else begin
			done <= entry_last && idx_last;
			if (start) begin
				active <= 1'b1;
				idx <= '0;
				phase <= '0;
			end else if (active) begin
				phase <= entry_last ? '0 : phase + 1'b1;
				if (entry_last) begin
					idx <= idx + 1'b1;
					if (idx_last) begin
						active <= 1'b0;
					end
				end
			end
		end
	end

	// size taken long after the read has landed
	always_ff @(posedge CLK) begin
		if (entry_last) begin
			sections[idx].size <= rd_data[ADDR_W-1:0];
			sections[idx].base <= (idx == '0) ? ADDR_W'(1) : prev_end + 1'b1;
		end
	end

endmodule

// File: src/beatmap_ram.sv
// beatmap word memory
`timescale 1ns/1ns

module beatmap_ram import mania_pkg::*; (
	input  logic              CLK,
	input  logic              wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [WORD_W-1:0] wr_data,
	input  logic              rd_en,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [WORD_W-1:0] rd_data
);

	logic [WORD_W-1:0] mem [2**ADDR_W];

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read data held between reads
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: src/beatmap_loader.sv
// beatmap byte stream loader
`timescale 1ns/1ns

module beatmap_loader import mania_pkg::*; (
	input  logic              CLK,
	input  logic              RESET_L,
	input  logic              start,
	input  logic [7:0]        song_selection,
	output storage_req_t      req,
	input  storage_rsp_t      rsp,
	output logic              wr_en,
	output logic [ADDR_W-1:0] wr_addr,
	output logic [WORD_W-1:0] wr_data,
	output logic              done
);

	typedef enum logic [2:0] {
		LD_IDLE,
		LD_RESTART,
		LD_REQ,
		LD_WAIT,
		LD_DONE
	} load_state_e;

	load_state_e state;
	logic [BYTE_POS_W-1:0] byte_pos;
	logic [WORD_W-1:0] word_sr;
	logic got_byte;
	logic word_full;

	assign got_byte = (state == LD_WAIT) && rsp.data_ready;
	assign word_full = (byte_pos == BYTE_POS_W'(WORD_BYTES - 1));

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= LD_IDLE;
		end else begin
			case (state)
				LD_IDLE: begin
					if (start) begin
						state <= LD_RESTART;
					end
				end
				LD_RESTART: begin
					state <= LD_REQ;
				end
				LD_REQ: begin
					state <= LD_WAIT;
				end
				LD_WAIT: begin
					if (rsp.transmit_finished) begin
						state <= LD_DONE;
					end else if (rsp.data_ready) begin
						state <= LD_REQ; // next byte
					end
				end
				default: begin
					state <= LD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			byte_pos <= '0;
			wr_addr <= '0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= got_byte && word_full;
			if (start) begin
				byte_pos <= '0;
				wr_addr <= '0;
			end else begin
				if (got_byte) begin
					byte_pos <= word_full ? '0 : byte_pos + 1'b1;
				end
				if (wr_en) begin
					wr_addr <= wr_addr + 1'b1;
				end
			end
		end
	end

	// first byte ends up in the low lane
	always_ff @(posedge CLK) begin
		if (got_byte) begin
			word_sr <= {rsp.data, word_sr[WORD_W-1:BYTE_W]};
		end
	end

	always_comb begin
		req.init_index = song_selection;
		req.init_aux_info = '0;
		req.restart = (state == LD_RESTART);
		req.request_data = (state == LD_REQ);
	end

	assign wr_data = word_sr;
	assign done = (state == LD_DONE);

endmodule

// File: src/tick_timer.sv
// game and audio tick counters
`timescale 1ns/1ns

module tick_timer import mania_pkg::*; (
	input  logic CLK,
	input  logic RESET_L,
	input  logic running,
	output logic update_tick,
	output logic audio_tick
);

	logic [1:0][TICK_CNT_W-1:0] cnt;
	logic [1:0] last;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			last[i] = running && (cnt[i] == TICK_LAST[i]);
		end
	end

	// both counters sit at zero until running
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			cnt <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (!running || last[i]) begin
					cnt[i] <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign update_tick = last[0];
	assign audio_tick = last[1];

endmodule

// File: src/boot_sequencer.sv
// boot order state machine
`timescale 1ns/1ns

module boot_sequencer import mania_pkg::*; (
	input  logic        CLK,
	input  logic        RESET_L,
	input  logic        load_done,
	input  logic        table_done,
	output logic        load_start,
	output logic        table_start,
	output logic        song_restart,
	output logic        running,
	output core_state_e state
);

	core_state_e next_state;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= ST_INIT;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			ST_INIT: begin
				next_state = ST_LOAD;
			end
			ST_LOAD: begin
				next_state = ST_W_LOAD;
			end
			ST_W_LOAD: begin
				next_state = load_done ? ST_SONG_RESET : ST_W_LOAD;
			end
			ST_SONG_RESET: begin
				next_state = ST_GET_BASE;
			end
			ST_GET_BASE: begin
				next_state = ST_W_GET_BASE;
			end
			ST_W_GET_BASE: begin
				next_state = table_done ? ST_RUN : ST_W_GET_BASE;
			end
			ST_RUN: begin
				next_state = ST_RUN; // left only by reset
			end
			default: begin
				next_state = ST_INIT;
			end
		endcase
	end

	// one-cycle states give the pulses
	assign load_start = (state == ST_LOAD);
	assign song_restart = (state == ST_SONG_RESET);
	assign table_start = (state == ST_GET_BASE);
	assign running = (state == ST_RUN);

endmodule

// File: src/mania_pkg.sv
// rhythm core shared definitions
package mania_pkg;

	localparam int BYTE_W = 8;
	localparam int WORD_BYTES = 3;
	localparam int WORD_W = BYTE_W * WORD_BYTES;
	localparam int ADDR_W = 13;
	localparam int NUM_SECTIONS = 4;

	// shortened for simulation
	localparam int UPDATE_PERIOD = 40;
	localparam int AUDIO_PERIOD = 8;
	localparam int PLAY_DELAY = 5; // in audio ticks
	localparam int ENTRY_CYCLES = 4;

	localparam int BYTE_POS_W = $clog2(WORD_BYTES);
	localparam int SEC_IDX_W = $clog2(NUM_SECTIONS);
	localparam int PHASE_W = $clog2(ENTRY_CYCLES);
	localparam int DELAY_CNT_W = $clog2(PLAY_DELAY + 1);
	localparam int TICK_CNT_W = $clog2(UPDATE_PERIOD); // update period is the longer one

	// last count of each period counter, update in slot 0
	localparam logic [1:0][TICK_CNT_W-1:0] TICK_LAST = {
		TICK_CNT_W'(AUDIO_PERIOD - 1),
		TICK_CNT_W'(UPDATE_PERIOD - 1)
	};

	typedef enum logic [2:0] {
		ST_INIT,
		ST_LOAD,
		ST_W_LOAD,
		ST_SONG_RESET,
		ST_GET_BASE,
		ST_W_GET_BASE,
		ST_RUN
	} core_state_e;

	typedef struct packed {
		logic [ADDR_W-1:0] size;
		logic [ADDR_W-1:0] base;
	} section_entry_t;

	typedef section_entry_t [NUM_SECTIONS-1:0] section_table_t;

	typedef struct packed {
		logic [7:0] init_index;
		logic [7:0] init_aux_info;
		logic       restart;
		logic       request_data;
	} storage_req_t;

	typedef struct packed {
		logic [BYTE_W-1:0] data;
		logic              data_ready;
		logic              transmit_finished;
	} storage_rsp_t;

endpackage
